/* uart_pkg.sv */
package uart_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // vector types
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  typedef logic [15:0] cmd_t;      // rw, address, data.
  typedef logic [7:0]  byte_t;     // one serial payload.
  typedef logic [6:0]  addr_t;     // register address.
  typedef logic [8:0]  baud_cnt_t; // counts one bit time.
  typedef logic [7:0]  gap_cnt_t;  // counts the write gap.

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // timing and layout constants
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // 115200 baud from a 50 MHz clock.
  localparam baud_cnt_t CLKS_PER_BIT = 9'd434;

  // receiver waits this long after the start edge.
  localparam baud_cnt_t HALF_BIT = CLKS_PER_BIT / 2;

  // idle line between address and data frame of a write.
  localparam gap_cnt_t FRAME_GAP = 8'd100;

  // 1 = write, 0 = read.
  localparam int CMD_RW_BIT = 15;

endpackage

/* uart_tx.sv */
module uart_tx (
  input  logic            clk,
  input  logic            rst_n,
  input  uart_pkg::byte_t tx_byte,
  input  logic            tx_vld,
  output logic            tx_rdy,
  output logic            tx
);
  import uart_pkg::*;

  typedef enum logic [2:0] {
    TX_IDLE,
    TX_START,
    TX_DATA,
    TX_PARITY,
    TX_STOP
  } tx_state_t;

  tx_state_t  state;
  baud_cnt_t  baud_cnt;
  logic [2:0] bit_idx;
  byte_t      shreg;
  logic       parity;
  logic       bit_end;

  assign tx_rdy  = (state == TX_IDLE);
  assign bit_end = (baud_cnt == CLKS_PER_BIT - 1'b1);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // frame sequencer
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state    <= TX_IDLE;
      baud_cnt <= '0;
      bit_idx  <= '0;
      tx       <= 1'b1;
    end
    else
    begin
      if (state == TX_IDLE || bit_end)
        baud_cnt <= '0;
      else
        baud_cnt <= baud_cnt + 1'b1;

      case (state)
        TX_IDLE:
        begin
          if (tx_vld)
          begin
            tx    <= 1'b0;      // start bit next cycle.
            state <= TX_START;
          end
        end
        TX_START:
        begin
          if (bit_end)
          begin
            tx      <= shreg[0];
            bit_idx <= '0;
            state   <= TX_DATA;
          end
        end
        TX_DATA:
        begin
          if (bit_end)
          begin
            bit_idx <= bit_idx + 1'b1;
            if (bit_idx == 3'd7)
            begin
              tx    <= parity;
              state <= TX_PARITY;
            end
            else
              tx <= shreg[0];   // lsb first.
          end
        end
        TX_PARITY:
        begin
          if (bit_end)
          begin
            tx    <= 1'b1;
            state <= TX_STOP;
          end
        end
        TX_STOP:
        begin
          if (bit_end)
            state <= TX_IDLE;
        end
        default:
          state <= TX_IDLE;
      endcase
    end
  end

  // byte and parity are taken once, at the handshake.
  always_ff @(posedge clk)
  begin
    if (tx_vld && tx_rdy)
    begin
      shreg  <= tx_byte;
      parity <= ~^tx_byte;      // odd parity.
    end
    else if (bit_end && (state == TX_START || state == TX_DATA))
      shreg <= shreg >> 1;
  end

endmodule

/* uart_rx.sv */
module uart_rx (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            rx,
  output uart_pkg::byte_t rx_byte,
  output logic            rx_err,
  output logic            rx_done
);
  import uart_pkg::*;

  typedef enum logic [2:0] {
    RX_IDLE,
    RX_START,
    RX_DATA,
    RX_PARITY,
    RX_STOP
  } rx_state_t;

  rx_state_t  state;
  logic [2:0] rx_sync;
  logic       rx_s;
  logic       rx_fall;
  baud_cnt_t  baud_cnt;
  logic [2:0] bit_idx;
  byte_t      shreg;
  logic       par_bit;
  logic       half_end;
  logic       bit_end;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // input synchronizer
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      rx_sync <= 3'b111;        // line idles high.
    else
      rx_sync <= {rx_sync[1:0], rx};
  end

  assign rx_s     = rx_sync[1];
  assign rx_fall  = rx_sync[2] && !rx_sync[1];
  assign half_end = (baud_cnt == HALF_BIT - 1'b1);
  assign bit_end  = (baud_cnt == CLKS_PER_BIT - 1'b1);
  assign rx_byte  = shreg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // mid-bit sampler
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state    <= RX_IDLE;
      baud_cnt <= '0;
      bit_idx  <= '0;
      rx_done  <= 1'b0;
    end
    else
    begin
      rx_done <= 1'b0;
      if (state == RX_IDLE || bit_end || (state == RX_START && half_end))
        baud_cnt <= '0;
      else
        baud_cnt <= baud_cnt + 1'b1;

      case (state)
        RX_IDLE:
        begin
          if (rx_fall)
            state <= RX_START;
        end
        RX_START:
        begin
          if (half_end)
          begin
            bit_idx <= '0;
            state   <= rx_s ? RX_IDLE : RX_DATA;   // glitch check.
          end
        end
        RX_DATA:
        begin
          if (bit_end)
          begin
            bit_idx <= bit_idx + 1'b1;
            if (bit_idx == 3'd7)
              state <= RX_PARITY;
          end
        end
        RX_PARITY:
        begin
          if (bit_end)
            state <= RX_STOP;
        end
        RX_STOP:
        begin
          if (bit_end)
          begin
            rx_done <= 1'b1;
            state   <= RX_IDLE;
          end
        end
        default:
          state <= RX_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (state == RX_DATA && bit_end)
      shreg <= {rx_s, shreg[7:1]};
    if (state == RX_PARITY && bit_end)
      par_bit <= rx_s;
    if (state == RX_STOP && bit_end)
      rx_err <= ~^{shreg, par_bit} || !rx_s;  // bad parity or stop.
  end

endmodule

/* uart_cmd_ctrl.sv */
module uart_cmd_ctrl (
  input  logic            clk,
  input  logic            rst_n,
  input  uart_pkg::cmd_t  cmd,
  input  logic            cmd_vld,
  output logic            cmd_rdy,
  output uart_pkg::byte_t tx_byte,
  output logic            tx_vld,
  input  logic            tx_rdy,
  input  uart_pkg::byte_t rx_byte,
  input  logic            rx_err,
  input  logic            rx_done,
  output uart_pkg::byte_t read_data,
  output logic            read_err,
  output logic            read_vld,
  input  logic            read_rdy
);
  import uart_pkg::*;

  typedef enum logic [2:0] {
    CTRL_IDLE,
    CTRL_SEND_ADDR,
    CTRL_WAIT_FRAME,
    CTRL_GAP,
    CTRL_SEND_DATA,
    CTRL_WAIT_REPLY,
    CTRL_REPLY_OUT
  } ctrl_state_t;

  ctrl_state_t state;
  cmd_t        cmd_q;
  addr_t       cmd_addr;
  logic        cmd_wr;
  logic        data_phase;
  gap_cnt_t    gap_cnt;
  logic        cmd_take;
  logic        tx_take;

  assign cmd_wr   = cmd_q[CMD_RW_BIT];
  assign cmd_addr = cmd_q[CMD_RW_BIT-1 -: $bits(addr_t)];

  // ready again on the first idle cycle after the data frame.
  assign cmd_rdy  = (state == CTRL_IDLE) ||
                    (state == CTRL_WAIT_FRAME && data_phase && tx_rdy);
  assign cmd_take = cmd_vld && cmd_rdy;

  assign tx_vld   = (state == CTRL_SEND_ADDR) || (state == CTRL_SEND_DATA);
  assign tx_take  = tx_vld && tx_rdy;
  assign tx_byte  = (state == CTRL_SEND_DATA) ? cmd_q[$bits(byte_t)-1:0]
                                              : {cmd_wr, cmd_addr};
  assign read_vld = (state == CTRL_REPLY_OUT);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // transaction FSM
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state      <= CTRL_IDLE;
      data_phase <= 1'b0;
      gap_cnt    <= '0;
    end
    else
    begin
      if (cmd_take)
        data_phase <= 1'b0;
      else if (state == CTRL_SEND_DATA && tx_take)
        data_phase <= 1'b1;

      case (state)
        CTRL_IDLE:
        begin
          if (cmd_take)
            state <= CTRL_SEND_ADDR;
        end
        CTRL_SEND_ADDR:
        begin
          if (tx_take)
            state <= cmd_wr ? CTRL_WAIT_FRAME : CTRL_WAIT_REPLY;
        end
        CTRL_WAIT_FRAME:
        begin
          if (tx_rdy)
          begin
            if (!data_phase)
            begin
              gap_cnt <= '0;
              state   <= CTRL_GAP;
            end
            else if (cmd_take)
              state <= CTRL_SEND_ADDR;  // back-to-back command.
            else
              state <= CTRL_IDLE;
          end
        end
        CTRL_GAP:
        begin
          if (gap_cnt == FRAME_GAP - 1'b1)
            state <= CTRL_SEND_DATA;
          else
            gap_cnt <= gap_cnt + 1'b1;
        end
        CTRL_SEND_DATA:
        begin
          if (tx_take)
            state <= CTRL_WAIT_FRAME;
        end
        CTRL_WAIT_REPLY:
        begin
          if (rx_done)
            state <= CTRL_REPLY_OUT;
        end
        CTRL_REPLY_OUT:
        begin
          if (read_rdy)
            state <= CTRL_IDLE;   // host took the reply.
        end
        default:
          state <= CTRL_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (cmd_take)
      cmd_q <= cmd;
    if (state == CTRL_WAIT_REPLY && rx_done)
    begin
      read_data <= rx_byte;
      read_err  <= rx_err;
    end
  end

endmodule

/* uart_cmd_top.sv */
module uart_cmd_top (
  input  logic            clk,
  input  logic            rst_n,
  input  uart_pkg::cmd_t  cmd,
  input  logic            cmd_vld,
  output logic            cmd_rdy,
  output uart_pkg::byte_t read_data,
  output logic            read_err,
  output logic            read_vld,
  input  logic            read_rdy,
  output logic            tx,
  input  logic            rx
);
  import uart_pkg::*;

  byte_t tx_byte;
  logic  tx_vld;
  logic  tx_rdy;
  byte_t rx_byte;
  logic  rx_err;
  logic  rx_done;

  uart_cmd_ctrl i_uart_cmd_ctrl (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd       (cmd),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .tx_byte   (tx_byte),
    .tx_vld    (tx_vld),
    .tx_rdy    (tx_rdy),
    .rx_byte   (rx_byte),
    .rx_err    (rx_err),
    .rx_done   (rx_done),
    .read_data (read_data),
    .read_err  (read_err),
    .read_vld  (read_vld),
    .read_rdy  (read_rdy)
  );

  uart_tx i_uart_tx (
    .clk     (clk),
    .rst_n   (rst_n),
    .tx_byte (tx_byte),
    .tx_vld  (tx_vld),
    .tx_rdy  (tx_rdy),
    .tx      (tx)
  );

  uart_rx i_uart_rx (
    .clk     (clk),
    .rst_n   (rst_n),
    .rx      (rx),
    .rx_byte (rx_byte),
    .rx_err  (rx_err),
    .rx_done (rx_done)
  );

endmodule

/* uart_cmd_asserts.sv */
module uart_cmd_asserts (
  input logic            clk,
  input logic            rst_n,
  input logic            cmd_rdy,
  input logic            read_vld,
  input logic            read_rdy,
  input uart_pkg::byte_t read_data,
  input logic            tx
);

  int fail_cnt = 0;

  // reply waits for the host unchanged.
  read_hold: assert property (@(posedge clk) disable iff (!rst_n)
    read_vld && !read_rdy |=> read_vld && $stable(read_data))
  else
  begin
    $error("read_vld or read_data changed while read_rdy was low");
    fail_cnt++;
  end

  idle_line: assert property (@(posedge clk) disable iff (!rst_n)
    cmd_rdy |-> tx)
  else
  begin
    $error("tx low while cmd_rdy is high");
    fail_cnt++;
  end

  one_owner: assert property (@(posedge clk) disable iff (!rst_n)
    !(cmd_rdy && read_vld))
  else
  begin
    $error("cmd_rdy and read_vld high together");
    fail_cnt++;
  end

endmodule

bind uart_cmd_top uart_cmd_asserts i_uart_cmd_asserts (
  .clk       (clk),
  .rst_n     (rst_n),
  .cmd_rdy   (cmd_rdy),
  .read_vld  (read_vld),
  .read_rdy  (read_rdy),
  .read_data (read_data),
  .tx        (tx)
);

/* tb_uart_cmd.sv */
module tb_uart_cmd;
  import uart_pkg::*;

  localparam int N_FIXED    = 6;
  localparam int N_ENT      = 10;
  localparam int FRAME_CLKS = 11 * CLKS_PER_BIT;

  typedef struct packed {
    cmd_t       cmd;
    byte_t      reply;
    logic       bad_par;
    logic [3:0] hold;
  } entry_t;

  logic  clk;
  logic  rst_n;
  cmd_t  cmd;
  logic  cmd_vld;
  logic  cmd_rdy;
  byte_t read_data;
  logic  read_err;
  logic  read_vld;
  logic  read_rdy;
  logic  tx;
  logic  rx;

  entry_t      tbl [N_ENT];
  logic [31:0] lfsr;
  int          cyc = 0;
  int          errors;
  int          n_fail;
  logic        ent_bad;
  byte_t       cur_reply;
  logic        cur_bad_par;
  event        rd_addr_ev;

  byte_t       fr_byte [$];
  logic [2:0]  fr_bits [$];     // start, parity, stop.
  int          fr_time [$];

  uart_cmd_top i_uart_cmd_top (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd       (cmd),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .read_data (read_data),
    .read_err  (read_err),
    .read_vld  (read_vld),
    .read_rdy  (read_rdy),
    .tx        (tx),
    .rx        (rx)
  );

  initial clk = 1'b0;
  always #5 clk = ~clk;

  always @(posedge clk)
    cyc <= cyc + 1;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // stimulus table
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  function automatic logic [15:0] rand_bits(input int n);
    logic [15:0] v;
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr = lfsr_next(lfsr);
      v    = {v[14:0], lfsr[0]};
    end
    return v;
  endfunction

  function automatic entry_t make_entry(input logic rw, input addr_t addr,
                                        input byte_t data, input byte_t reply,
                                        input logic bad, input logic [3:0] hold);
    entry_t e;
    e.cmd     = {rw, addr, data};
    e.reply   = reply;
    e.bad_par = bad;
    e.hold    = hold;
    return e;
  endfunction

  task automatic build_table();
    addr_t      a;
    byte_t      d;
    byte_t      r;
    logic [3:0] h;
    tbl[0] = make_entry(1'b1, 7'h12, 8'ha5, 8'h00, 1'b0, 4'd0);
    tbl[1] = make_entry(1'b0, 7'h34, 8'h00, 8'h5c, 1'b0, 4'd0);
    tbl[2] = make_entry(1'b0, 7'h7f, 8'h00, 8'hff, 1'b1, 4'd3);
    tbl[3] = make_entry(1'b0, 7'h00, 8'h00, 8'h00, 1'b0, 4'd9);
    tbl[4] = make_entry(1'b1, 7'h7f, 8'h00, 8'h00, 1'b0, 4'd0);   // data byte looks like a read.
    tbl[5] = make_entry(1'b1, 7'h01, 8'hff, 8'h00, 1'b0, 4'd0);
    for (int i = N_FIXED; i < N_ENT; i++)
    begin
      a = addr_t'(rand_bits(7));
      d = byte_t'(rand_bits(8));
      r = byte_t'(rand_bits(8));
      h = 4'(rand_bits(4));
      tbl[i] = make_entry(i[0], a, d, r, i == N_ENT - 2, h);
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // checks
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic check_byte(input string name, input byte_t exp, input byte_t act);
    if (act !== exp)
    begin
      $display("error: %s expected %h, got %h", name, exp, act);
      errors++;
      ent_bad = 1'b1;
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp)
    begin
      $display("error: %s expected %h, got %h", name, exp, act);
      errors++;
      ent_bad = 1'b1;
    end
  endtask

  task automatic get_frame(output byte_t b, output int t);
    logic [2:0] s;
    while (fr_byte.size() == 0)
      @(negedge clk);
    b = fr_byte.pop_front();
    s = fr_bits.pop_front();
    t = fr_time.pop_front();
    check_bit("start bit", 1'b0, s[2]);
    check_bit("parity", 1'b1, ^{b, s[1]});   // odd over data and parity.
    check_bit("stop bit", 1'b1, s[0]);
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // serial side
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  initial
  begin : serial_monitor
    byte_t      b;
    logic [2:0] s;
    int         t;
    logic       data_next;
    data_next = 1'b0;
    forever
    begin
      @(negedge clk);
      if (rst_n === 1'b1 && tx === 1'b0)
      begin
        t = cyc;
        repeat (HALF_BIT)
          @(negedge clk);
        s[2] = tx;
        for (int i = 0; i < 8; i++)
        begin
          repeat (CLKS_PER_BIT)
            @(negedge clk);
          b[i] = tx;
        end
        repeat (CLKS_PER_BIT)
          @(negedge clk);
        s[1] = tx;
        repeat (CLKS_PER_BIT)
          @(negedge clk);
        s[0] = tx;
        fr_byte.push_back(b);
        fr_bits.push_back(s);
        fr_time.push_back(t);
        if (!data_next && !b[7])
          -> rd_addr_ev;              // read address seen.
        data_next = !data_next && b[7];
      end
    end
  end

  task automatic send_reply(input byte_t b, input logic flip);
    logic [10:0] frame;
    frame = {1'b1, (~^b) ^ flip, b, 1'b0};
    for (int i = 0; i < 11; i++)
    begin
      @(posedge clk);
      rx <= frame[i];
      repeat (CLKS_PER_BIT - 1)
        @(posedge clk);
    end
  endtask

  initial
  begin : peripheral_model
    forever
    begin
      @(rd_addr_ev);
      send_reply(cur_reply, cur_bad_par);
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // host side
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic send_cmd(input cmd_t c);
    @(posedge clk);
    cmd     <= c;
    cmd_vld <= 1'b1;
    do
      @(negedge clk);
    while (!cmd_rdy);
    @(posedge clk);
    cmd_vld <= 1'b0;
  endtask

  task automatic run_write(input entry_t e);
    byte_t b;
    int    t1;
    int    t2;
    get_frame(b, t1);
    check_byte("address frame", {1'b1, e.cmd[14:8]}, b);
    get_frame(b, t2);
    check_byte("data frame", e.cmd[7:0], b);
    if (t2 - t1 < FRAME_CLKS + FRAME_GAP)
    begin
      $display("write frames only %0d idle cycles apart", t2 - t1 - FRAME_CLKS);
      errors++;
      ent_bad = 1'b1;
    end
    do
    begin
      @(negedge clk);
      check_bit("read_vld", 1'b0, read_vld);
    end
    while (!cmd_rdy);
  endtask

  task automatic run_read(input entry_t e);
    byte_t b;
    int    t;
    get_frame(b, t);
    check_byte("address frame", {1'b0, e.cmd[14:8]}, b);
    while (!read_vld)
      @(negedge clk);
    check_byte("read_data", e.reply, read_data);
    check_bit("read_err", e.bad_par, read_err);
    repeat (e.hold)
    begin
      @(negedge clk);
      check_bit("read_vld", 1'b1, read_vld);
      check_byte("read_data", e.reply, read_data);
      check_bit("cmd_rdy", 1'b0, cmd_rdy);
      check_bit("tx", 1'b1, tx);
    end
    @(posedge clk);
    read_rdy <= 1'b1;
    @(posedge clk);
    read_rdy <= 1'b0;                 // transfer on this edge.
    @(negedge clk);
    check_bit("read_vld", 1'b0, read_vld);
    check_bit("cmd_rdy", 1'b1, cmd_rdy);
  endtask

  initial
  begin : main
    entry_t e;
    lfsr        = 32'hf6b5_34ac;
    errors      = 0;
    n_fail      = 0;
    rst_n       = 1'b0;
    cmd         = '0;
    cmd_vld     = 1'b0;
    read_rdy    = 1'b0;
    rx          = 1'b1;
    cur_reply   = '0;
    cur_bad_par = 1'b0;
    build_table();
    repeat (4)
      @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    ent_bad = 1'b0;
    check_bit("tx", 1'b1, tx);
    check_bit("cmd_rdy", 1'b1, cmd_rdy);
    check_bit("read_vld", 1'b0, read_vld);
    $display("reset state: %s", ent_bad ? "failed" : "ok");
    for (int i = 0; i < N_ENT; i++)
    begin
      e           = tbl[i];
      ent_bad     = 1'b0;
      cur_reply   = e.reply;
      cur_bad_par = e.bad_par;
      send_cmd(e.cmd);
      if (e.cmd[CMD_RW_BIT])
        run_write(e);
      else
        run_read(e);
      if (ent_bad)
        n_fail++;
      $display("entry %0d %s cmd %h: %s", i, e.cmd[CMD_RW_BIT] ? "write" : "read",
               e.cmd, ent_bad ? "failed" : "ok");
    end
    errors += i_uart_cmd_top.i_uart_cmd_asserts.fail_cnt;
    $display("entries %0d, failed %0d, errors %0d", N_ENT, n_fail, errors);
    if (errors == 0)
      $display("** PASS **");
    else
      $display("** FAIL **");
    $finish;
  end

  initial
  begin : watchdog
    int limit;
    int max_hold;
    @(posedge rst_n);
    max_hold = 0;
    foreach (tbl[i])
      if (tbl[i].hold > max_hold)
        max_hold = tbl[i].hold;
    limit = N_ENT * (3 * FRAME_CLKS + FRAME_GAP + max_hold + 200);
    repeat (limit)
      @(posedge clk);
    $display("timeout: the tests did not finish within %0d cycles", limit);
    $display("** FAIL **");
    $finish;
  end

endmodule

/* files.f */
uart_pkg.sv
uart_tx.sv
uart_rx.sv
uart_cmd_ctrl.sv
uart_cmd_top.sv
uart_cmd_asserts.sv
tb_uart_cmd.sv

/* Makefile */
# Verilator build and run for the UART command master testbench.

VERILATOR ?= verilator
TOP       ?= tb_uart_cmd
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) 2>&1 | tee $(LOG)
	@grep -qF -- '** PASS **' $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
